// File: build.f
+incdir+tests
common/cpuPkg.sv
exception/exceptionUnit.sv
cp0/cp0Regs.sv
hw/excSubsystem.sv
tests/tbExcSubsystem.sv

// File: Makefile
TOP = tbExcSubsystem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module excSubsystem
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o simv
	out=$$(./obj_dir/simv); echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// File: tests/excVectors.svh
// stimulus and expected-value rows for the exception subsystem testbench, included in its module
// row: flags, tlb, pc, addr (0 = random filler), status, ipSw, hwInt / stall, excCode,
// entrySel, redirectPc, flush / epc, cause, badVAddr read back after the commit edge

    task automatic loadVectors();
        addRow(12'h221, cpuPkg::TlbNone, 32'h400100, 32'h0, 32'h400000, 2'd0, 6'h00,
               1'b0, cpuPkg::ExcRefetch, cpuPkg::SelRefetch, 32'h400100, 1'b0,
               32'h0, 32'h0, 32'h0); // refetch beats everything
        addRow(12'h028, cpuPkg::TlbNone, 32'h400201, 32'h0, 32'h401, 2'd0, 6'h01,
               1'b0, cpuPkg::ExcInt, cpuPkg::SelException, 32'h9abcd180, 1'b1,
               32'h400201, 32'h400, 32'h0);
        addRow(12'h020, cpuPkg::TlbNone, 32'h400300, 32'h0, 32'h400, 2'd0, 6'h01,
               1'b0, cpuPkg::ExcSys, cpuPkg::SelException, 32'h9abcd180, 1'b1,
               32'h400300, 32'h420, 32'h0); // IE clear
        addRow(12'h000, cpuPkg::TlbNone, 32'h400400, 32'h0, 32'h801, 2'd0, 6'h01,
               1'b0, cpuPkg::ExcNone, cpuPkg::SelNone, 32'h0, 1'b0,
               32'h400300, 32'h420, 32'h0); // IM does not match
        addRow(12'h000, cpuPkg::TlbNone, 32'h400500, 32'h0, 32'h201, 2'd2, 6'h00,
               1'b0, cpuPkg::ExcInt, cpuPkg::SelException, 32'h9abcd180, 1'b1,
               32'h400500, 32'h200, 32'h0); // software IP1
        addRow(12'h000, cpuPkg::TlbNone, 32'h0, 32'h0, 32'h201, 2'd2, 6'h00,
               1'b0, cpuPkg::ExcNone, cpuPkg::SelNone, 32'h0, 1'b0,
               32'h400500, 32'h200, 32'h0); // zero PC
        addRow(12'h012, cpuPkg::TlbNone, 32'h400602, 32'h0, 32'h400000, 2'd0, 6'h00,
               1'b0, cpuPkg::ExcAdEL, cpuPkg::SelException, 32'hbfc00380, 1'b1,
               32'h400602, 32'h10, 32'h400602);
        addRow(12'h00e, cpuPkg::TlbNone, 32'h400700, 32'h0, 32'h0, 2'd0, 6'h00,
               1'b0, cpuPkg::ExcTlbL, cpuPkg::SelException, 32'h9abcd000, 1'b1,
               32'h400700, 32'h08, 32'h400700); // refill entry
        addRow(12'h002, cpuPkg::TlbNone, 32'h400800, 32'h0, 32'h403, 2'd0, 6'h01,
               1'b0, cpuPkg::ExcTlbL, cpuPkg::SelException, 32'h9abcd180, 1'b1,
               32'h400700, 32'h408, 32'h400800); // EXL masks the interrupt and keeps EPC
        addRow(12'h380, cpuPkg::TlbNone, 32'h400900, 32'h0, 32'h2, 2'd0, 6'h00,
               1'b0, cpuPkg::ExcEret, cpuPkg::SelEret, 32'h400700, 1'b1,
               32'h400700, 32'h08, 32'h400800);
        addRow(12'hc78, cpuPkg::TlbNone, 32'h400a00, 32'h0, 32'h400000, 2'd0, 6'h00,
               1'b0, cpuPkg::ExcCpU, cpuPkg::SelException, 32'hbfc00380, 1'b1,
               32'h400a00, 32'h2c, 32'h400800);
        addRow(12'hc00, cpuPkg::RdRefill, 32'h400b00, 32'h10000003, 32'h400000, 2'd0, 6'h00,
               1'b0, cpuPkg::ExcAdES, cpuPkg::SelException, 32'hbfc00380, 1'b1,
               32'h400b00, 32'h14, 32'h10000003);
        addRow(12'h000, cpuPkg::WrRefill, 32'h400c00, 32'h20004000, 32'h0, 2'd0, 6'h00,
               1'b0, cpuPkg::ExcTlbS, cpuPkg::SelException, 32'h9abcd000, 1'b1,
               32'h400c00, 32'h0c, 32'h20004000);
        addRow(12'h000, cpuPkg::Modified, 32'h400d00, 32'h20005000, 32'h400000, 2'd0, 6'h00,
               1'b0, cpuPkg::ExcMod, cpuPkg::SelException, 32'hbfc00380, 1'b1,
               32'h400d00, 32'h04, 32'h20005000);
        addRow(12'h000, cpuPkg::RdInvalid, 32'h400e00, 32'h30006000, 32'h400000, 2'd0, 6'h00,
               1'b1, cpuPkg::ExcTlbL, cpuPkg::SelException, 32'hbfc00380, 1'b0,
               32'h400d00, 32'h04, 32'h20005000); // stalled, nothing commits
    endtask

// File: tests/tbExcSubsystem.sv
// self-checking testbench for the exception subsystem; applies the vector table over APB and pipeline
`timescale 1ns/1ps

module tbExcSubsystem;

    localparam int          ApbTimeout = 20;
    localparam int          MaxRows    = 32;
    localparam logic [31:0] EbaseUser  = 32'h9abcd000;

    logic                        clk;
    logic                        rst;
    logic                        memValid;
    logic                        memStall;
    logic [31:0]                 memPc;
    logic [31:0]                 memAddr;
    logic [cpuPkg::ExcFlagW-1:0] excFlags;
    cpuPkg::tlbExcT              memTlbExc;
    logic [5:0]                  hwInt;
    logic [cpuPkg::ApbAddrW-1:0] paddr;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [31:0]                 pwdata;
    logic [31:0]                 prdata;
    logic                        pready;
    logic                        pslverr;
    logic                        flush;
    cpuPkg::entrySelT            entrySel;
    logic [31:0]                 redirectPc;
    cpuPkg::excCodeT             excCode;

    logic [11:0] rowFlags  [MaxRows];
    logic [2:0]  rowTlb    [MaxRows];
    logic [31:0] rowPc     [MaxRows];
    logic [31:0] rowAddr   [MaxRows];
    logic [31:0] rowStatus [MaxRows];
    logic [1:0]  rowIpSw   [MaxRows];
    logic [5:0]  rowHw     [MaxRows];
    logic        rowStall  [MaxRows];
    logic [4:0]  rowCode   [MaxRows];
    logic [1:0]  rowSel    [MaxRows];
    logic [31:0] rowRedir  [MaxRows];
    logic        rowFlush  [MaxRows];
    logic [31:0] rowEpc    [MaxRows];
    logic [31:0] rowCause  [MaxRows];
    logic [31:0] rowBad    [MaxRows];
    int          rowCount;
    int          errorCount;
    int          checkCount;
    integer      seed;

    excSubsystem u_excSubsystem (.*);

    always #4 clk = ~clk;

    task automatic addRow(
        input logic [11:0] flags,
        input logic [2:0]  tlb,
        input logic [31:0] pc, addr, status,
        input logic [1:0]  ipSw,
        input logic [5:0]  hw,
        input logic        stall,
        input logic [4:0]  code,
        input logic [1:0]  sel,
        input logic [31:0] expPc,
        input logic        expFlush,
        input logic [31:0] expEpc, expCause, expBad
    );
        rowFlags[rowCount]  = flags;
        rowTlb[rowCount]    = tlb;
        rowPc[rowCount]     = pc;
        rowAddr[rowCount]   = addr;
        rowStatus[rowCount] = status;
        rowIpSw[rowCount]   = ipSw;
        rowHw[rowCount]     = hw;
        rowStall[rowCount]  = stall;
        rowCode[rowCount]   = code;
        rowSel[rowCount]    = sel;
        rowRedir[rowCount]  = expPc;
        rowFlush[rowCount]  = expFlush;
        rowEpc[rowCount]    = expEpc;
        rowCause[rowCount]  = expCause;
        rowBad[rowCount]    = expBad;
        rowCount++;
    endtask

    `include "excVectors.svh"

    task automatic compareWord(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // one APB transfer; returns on the completion edge
    task automatic apbTransfer(input logic wr, input logic [cpuPkg::ApbAddrW-1:0] addr,
                               input logic [31:0] data, output logic [31:0] rdData);
        int waitCnt;
        waitCnt = 0;
        rdData  = 32'b0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && waitCnt < ApbTimeout) begin
            @(negedge clk);
            waitCnt++;
        end
        if (!pready) begin
            $display("APB transfer at address %h got no pready in %0d cycles", addr, waitCnt);
            $display("Checks failed");
            $finish;
        end else begin
            rdData = prdata;
            compareWord("pslverr", 32'(pslverr), 32'd0);
            @(posedge clk);
            psel    <= 1'b0;
            penable <= 1'b0;
            pwrite  <= 1'b0;
        end
    endtask

    initial begin
        logic [31:0] rdVal;
        logic [31:0] addrFill;
        logic [31:0] expStatus;
        seed       = 32'h440d;
        errorCount = 0;
        checkCount = 0;
        rowCount   = 0;
        clk        = 1'b0;
        rst        = 1'b1;
        memValid   = 1'b0;
        memStall   = 1'b0;
        memPc      = 32'b0;
        memAddr    = 32'b0;
        excFlags   = '0;
        memTlbExc  = cpuPkg::TlbNone;
        hwInt      = 6'b0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = 32'b0;
        loadVectors();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compareWord("flush", 32'(flush), 32'd0);
        apbTransfer(1'b0, cpuPkg::AddrStatus, 32'b0, rdVal);
        compareWord("status", rdVal, 32'h00400000);
        apbTransfer(1'b0, cpuPkg::AddrEbase, 32'b0, rdVal);
        compareWord("ebase", rdVal, cpuPkg::EbaseReset);
        apbTransfer(1'b1, cpuPkg::AddrEbase, EbaseUser, rdVal);
        apbTransfer(1'b0, cpuPkg::AddrEbase, 32'b0, rdVal);
        compareWord("ebase", rdVal, EbaseUser);

        for (int i = 0; i < rowCount; i++) begin
            hwInt <= rowHw[i]; // sampled into Cause a cycle later
            apbTransfer(1'b1, cpuPkg::AddrStatus, rowStatus[i], rdVal);
            apbTransfer(1'b1, cpuPkg::AddrCause, {22'b0, rowIpSw[i], 8'b0}, rdVal);
            addrFill = (rowAddr[i] == 32'b0) ? $random(seed) : rowAddr[i];
            memValid  <= 1'b1;
            memStall  <= rowStall[i];
            memPc     <= rowPc[i];
            memAddr   <= addrFill;
            excFlags  <= rowFlags[i];
            memTlbExc <= cpuPkg::tlbExcT'(rowTlb[i]);
            @(negedge clk);
            compareWord("excCode", 32'(excCode), 32'(rowCode[i]));
            compareWord("entrySel", 32'(entrySel), 32'(rowSel[i]));
            compareWord("redirectPc", redirectPc, rowRedir[i]);
            compareWord("flush", 32'(flush), 32'(rowFlush[i]));
            @(posedge clk);
            memValid  <= 1'b0;
            memStall  <= 1'b0;
            excFlags  <= '0;
            memTlbExc <= cpuPkg::TlbNone;
            expStatus = rowStatus[i];
            if (rowFlush[i]) begin
                expStatus[1] = (rowSel[i] != 2'(cpuPkg::SelEret)); // EXL set, or cleared on eret
            end
            apbTransfer(1'b0, cpuPkg::AddrStatus, 32'b0, rdVal);
            compareWord("status", rdVal, expStatus);
            apbTransfer(1'b0, cpuPkg::AddrEpc, 32'b0, rdVal);
            compareWord("epc", rdVal, rowEpc[i]);
            apbTransfer(1'b0, cpuPkg::AddrCause, 32'b0, rdVal);
            compareWord("cause", rdVal, rowCause[i]);
            apbTransfer(1'b0, cpuPkg::AddrBadVAddr, 32'b0, rdVal);
            compareWord("badVAddr", rdVal, rowBad[i]);
        end

        $display("%0d checks run, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: hw/excSubsystem.sv
// exception subsystem top; connects the cause prioritizer to the CP0 register block
`timescale 1ns/1ps

module excSubsystem (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         memValid,
    input  logic                         memStall,
    input  logic [31:0]                  memPc,
    input  logic [31:0]                  memAddr,
    input  logic [cpuPkg::ExcFlagW-1:0]  excFlags,
    input  cpuPkg::tlbExcT               memTlbExc,
    input  logic [5:0]                   hwInt,
    input  logic [cpuPkg::ApbAddrW-1:0]  paddr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic                         flush,
    output cpuPkg::entrySelT             entrySel,
    output logic [31:0]                  redirectPc,
    output cpuPkg::excCodeT              excCode
);

    logic            statusBev;
    logic [7:0]      statusIm;
    logic            statusExl;
    logic            statusIe;
    logic [7:0]      causeIp;
    logic [31:0]     ebase;
    logic [31:0]     epc;
    logic            excCommit;
    logic            eretCommit;
    cpuPkg::excCodeT commitCode;
    logic [31:0]     commitPc;
    logic [31:0]     commitBadAddr;
    logic            badAddrValid;

    exceptionUnit u_exceptionUnit (
        .memValid      (memValid),
        .memStall      (memStall),
        .memPc         (memPc),
        .memAddr       (memAddr),
        .excFlags      (excFlags),
        .memTlbExc     (memTlbExc),
        .statusBev     (statusBev),
        .statusIm      (statusIm),
        .statusExl     (statusExl),
        .statusIe      (statusIe),
        .causeIp       (causeIp),
        .ebase         (ebase),
        .epc           (epc),
        .flush         (flush),
        .entrySel      (entrySel),
        .redirectPc    (redirectPc),
        .excCode       (excCode),
        .excCommit     (excCommit),
        .eretCommit    (eretCommit),
        .commitCode    (commitCode),
        .commitPc      (commitPc),
        .commitBadAddr (commitBadAddr),
        .badAddrValid  (badAddrValid)
    );

    cp0Regs u_cp0Regs (
        .clk           (clk),
        .rst           (rst),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .hwInt         (hwInt),
        .excCommit     (excCommit),
        .eretCommit    (eretCommit),
        .commitCode    (commitCode),
        .commitPc      (commitPc),
        .commitBadAddr (commitBadAddr),
        .badAddrValid  (badAddrValid),
        .statusBev     (statusBev),
        .statusIm      (statusIm),
        .statusExl     (statusExl),
        .statusIe      (statusIe),
        .causeIp       (causeIp),
        .ebase         (ebase),
        .epc           (epc)
    );

endmodule

// File: cp0/cp0Regs.sv
// CP0 Status, Cause, EPC, BadVAddr and EBase with APB access and exception/eret commit
`timescale 1ns/1ps

module cp0Regs (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [cpuPkg::ApbAddrW-1:0]  paddr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    input  logic [5:0]                   hwInt,
    input  logic                         excCommit,
    input  logic                         eretCommit,
    input  cpuPkg::excCodeT              commitCode,
    input  logic [31:0]                  commitPc,
    input  logic [31:0]                  commitBadAddr,
    input  logic                         badAddrValid,
    output logic                         statusBev,
    output logic [7:0]                   statusIm,
    output logic                         statusExl,
    output logic                         statusIe,
    output logic [7:0]                   causeIp,
    output logic [31:0]                  ebase,
    output logic [31:0]                  epc
);

    logic            access;
    logic            addrHit;
    logic            wrEn;
    logic [5:0]      ipHw;       // sampled hardware lines, IP7:2
    logic [1:0]      ipSw;       // software interrupts, IP1:0
    cpuPkg::excCodeT causeCode;
    logic [31:0]     badVAddr;
    logic [17:0]     ebaseField; // EBase 29:12
    logic [31:0]     rdData;

    assign access  = psel && penable;
    assign pready  = 1'b1; // no wait states
    assign addrHit = (paddr == cpuPkg::AddrStatus) || (paddr == cpuPkg::AddrCause)
                     || (paddr == cpuPkg::AddrEpc) || (paddr == cpuPkg::AddrBadVAddr)
                     || (paddr == cpuPkg::AddrEbase);
    assign pslverr = access && !addrHit;
    // commit owns the edge, so a concurrent write is dropped
    assign wrEn    = access && pwrite && !excCommit && !eretCommit;

    assign causeIp = {ipHw, ipSw};
    assign ebase   = {cpuPkg::EbaseReset[31:30], ebaseField, 12'h000};

    always_ff @(posedge clk) begin
        if (rst) begin
            statusBev <= 1'b1;
            statusIm  <= 8'b0;
            statusExl <= 1'b0;
            statusIe  <= 1'b0;
        end else if (excCommit) begin
            statusExl <= 1'b1;
        end else if (eretCommit) begin
            statusExl <= 1'b0;
        end else if (wrEn && paddr == cpuPkg::AddrStatus) begin
            statusBev <= pwdata[cpuPkg::StatusBevBit];
            statusIm  <= pwdata[15:8];
            statusExl <= pwdata[cpuPkg::StatusExlBit];
            statusIe  <= pwdata[cpuPkg::StatusIeBit];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ipHw      <= 6'b0;
            ipSw      <= 2'b0;
            causeCode <= cpuPkg::ExcInt;
            badVAddr  <= 32'b0;
        end else begin
            ipHw <= hwInt; // one cycle behind the pins
            if (excCommit) begin
                causeCode <= commitCode;
                if (badAddrValid) begin
                    badVAddr <= commitBadAddr;
                end
            end else if (wrEn && paddr == cpuPkg::AddrCause) begin
                ipSw <= pwdata[9:8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            epc <= 32'b0;
        end else if (excCommit) begin
            if (!statusExl) begin
                epc <= commitPc; // nested exception keeps the first EPC
            end
        end else if (wrEn && paddr == cpuPkg::AddrEpc) begin
            epc <= pwdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ebaseField <= cpuPkg::EbaseReset[29:12];
        end else if (wrEn && paddr == cpuPkg::AddrEbase) begin
            ebaseField <= pwdata[29:12];
        end
    end

    always_comb begin
        case (paddr)
            cpuPkg::AddrStatus:   rdData = {9'b0, statusBev, 6'b0, statusIm, 6'b0, statusExl, statusIe};
            cpuPkg::AddrCause:    rdData = {16'b0, causeIp, 1'b0, causeCode, 2'b0};
            cpuPkg::AddrEpc:      rdData = epc;
            cpuPkg::AddrBadVAddr: rdData = badVAddr;
            cpuPkg::AddrEbase:    rdData = ebase;
            default:              rdData = 32'b0;
        endcase
    end

    assign prdata = (access && !pwrite) ? rdData : 32'b0;

    // exception and eret commit never arrive on the same edge
    commitExclusive: assert property (@(posedge clk) disable iff (rst)
        !(excCommit && eretCommit));

    apbSetupPhase: assert property (@(posedge clk) disable iff (rst)
        $rose(psel) |-> !penable);

endmodule

// File: exception/exceptionUnit.sv
// combinational exception prioritizer; picks the memory-stage cause and drives redirect and CP0 commit
`timescale 1ns/1ps

module exceptionUnit (
    input  logic                         memValid,
    input  logic                         memStall,
    input  logic [31:0]                  memPc,
    input  logic [31:0]                  memAddr,
    input  logic [cpuPkg::ExcFlagW-1:0]  excFlags,
    input  cpuPkg::tlbExcT               memTlbExc,
    input  logic                         statusBev,
    input  logic [7:0]                   statusIm,
    input  logic                         statusExl,
    input  logic                         statusIe,
    input  logic [7:0]                   causeIp,
    input  logic [31:0]                  ebase,
    input  logic [31:0]                  epc,
    output logic                         flush,
    output cpuPkg::entrySelT             entrySel,
    output logic [31:0]                  redirectPc,
    output cpuPkg::excCodeT              excCode,
    output logic                         excCommit,
    output logic                         eretCommit,
    output cpuPkg::excCodeT              commitCode,
    output logic [31:0]                  commitPc,
    output logic [31:0]                  commitBadAddr,
    output logic                         badAddrValid
);

    logic        intPending;
    logic        ifAddrErr;
    logic        isRefill;  // selected cause is a TLB refill
    logic        badFromPc; // faulting address is the fetch PC
    logic        fire;
    logic [31:0] vecBase;
    logic [31:0] vecOffset;

    assign intPending = (memPc != 32'b0) && ((causeIp & statusIm) != 8'b0)
                        && !statusExl && statusIe;
    assign ifAddrErr  = (memPc[1:0] != 2'b00);

    always_comb begin
        excCode      = cpuPkg::ExcNone;
        isRefill     = 1'b0;
        badAddrValid = 1'b0;
        badFromPc    = 1'b0;
        if (excFlags[cpuPkg::FlagRefetch]) begin
            excCode = cpuPkg::ExcRefetch;
        end else if (intPending) begin
            excCode = cpuPkg::ExcInt;
        end else if (ifAddrErr) begin
            excCode      = cpuPkg::ExcAdEL;
            badAddrValid = 1'b1;
            badFromPc    = 1'b1;
        end else if (excFlags[cpuPkg::FlagTlbRefillIf]) begin
            excCode      = cpuPkg::ExcTlbL;
            isRefill     = 1'b1;
            badAddrValid = 1'b1;
            badFromPc    = 1'b1;
        end else if (excFlags[cpuPkg::FlagTlbInvalidIf]) begin
            excCode      = cpuPkg::ExcTlbL;
            badAddrValid = 1'b1;
            badFromPc    = 1'b1;
        end else if (excFlags[cpuPkg::FlagCpU]) begin
            excCode = cpuPkg::ExcCpU;
        end else if (excFlags[cpuPkg::FlagRi]) begin
            excCode = cpuPkg::ExcRi;
        end else if (excFlags[cpuPkg::FlagSyscall]) begin
            excCode = cpuPkg::ExcSys;
        end else if (excFlags[cpuPkg::FlagBreak]) begin
            excCode = cpuPkg::ExcBp;
        end else if (excFlags[cpuPkg::FlagEret]) begin
            excCode = cpuPkg::ExcEret;
        end else if (excFlags[cpuPkg::FlagTrap]) begin
            excCode = cpuPkg::ExcTr;
        end else if (excFlags[cpuPkg::FlagOverflow]) begin
            excCode = cpuPkg::ExcOv;
        end else if (excFlags[cpuPkg::FlagWrAddrErr]) begin
            excCode      = cpuPkg::ExcAdES;
            badAddrValid = 1'b1;
        end else if (excFlags[cpuPkg::FlagRdAddrErr]) begin
            excCode      = cpuPkg::ExcAdEL;
            badAddrValid = 1'b1;
        end else if (memTlbExc != cpuPkg::TlbNone) begin
            badAddrValid = 1'b1;
            isRefill     = (memTlbExc == cpuPkg::RdRefill) || (memTlbExc == cpuPkg::WrRefill);
            case (memTlbExc)
                cpuPkg::RdRefill, cpuPkg::RdInvalid: excCode = cpuPkg::ExcTlbL;
                cpuPkg::WrRefill, cpuPkg::WrInvalid: excCode = cpuPkg::ExcTlbS;
                default:                             excCode = cpuPkg::ExcMod;
            endcase
        end
    end

    always_comb begin
        case (excCode)
            cpuPkg::ExcRefetch: entrySel = cpuPkg::SelRefetch;
            cpuPkg::ExcEret:    entrySel = cpuPkg::SelEret;
            cpuPkg::ExcNone:    entrySel = cpuPkg::SelNone;
            default:            entrySel = cpuPkg::SelException;
        endcase
    end

    assign vecBase   = statusBev ? cpuPkg::BootBase : ebase;
    assign vecOffset = (isRefill && !statusExl) ? 32'h0 : cpuPkg::GenOffset; // refill entry at +0

    always_comb begin
        case (entrySel)
            cpuPkg::SelException: redirectPc = vecBase + vecOffset;
            cpuPkg::SelEret:      redirectPc = epc;
            cpuPkg::SelRefetch:   redirectPc = memPc; // replay same instruction
            default:              redirectPc = 32'b0;
        endcase
    end

    assign fire          = memValid && !memStall;
    assign excCommit     = fire && (entrySel == cpuPkg::SelException);
    assign eretCommit    = fire && (entrySel == cpuPkg::SelEret);
    assign flush         = excCommit || eretCommit;
    assign commitCode    = excCode;
    assign commitPc      = memPc;
    assign commitBadAddr = badFromPc ? memPc : memAddr;

endmodule

// File: common/cpuPkg.sv
// shared exception codes, redirect kinds, flag positions and CP0 constants for the exception path
package cpuPkg;

    typedef enum logic [4:0] {
        ExcInt     = 5'd0,
        ExcMod     = 5'd1,
        ExcTlbL    = 5'd2,
        ExcTlbS    = 5'd3,
        ExcAdEL    = 5'd4,
        ExcAdES    = 5'd5,
        ExcSys     = 5'd8,
        ExcBp      = 5'd9,
        ExcRi      = 5'd10,
        ExcCpU     = 5'd11,
        ExcOv      = 5'd12,
        ExcTr      = 5'd13,
        ExcEret    = 5'd29, // internal, never written to Cause
        ExcRefetch = 5'd30, // internal
        ExcNone    = 5'd31  // internal
    } excCodeT;

    typedef enum logic [1:0] {
        SelNone,
        SelException,
        SelEret,
        SelRefetch
    } entrySelT;

    // fault reported by the data TLB lookup in the memory stage
    typedef enum logic [2:0] {
        TlbNone,
        RdRefill,
        RdInvalid,
        WrRefill,
        WrInvalid,
        Modified
    } tlbExcT;

    localparam int FlagRefetch      = 0;
    localparam int FlagTlbRefillIf  = 1;
    localparam int FlagTlbInvalidIf = 2;
    localparam int FlagCpU          = 3;
    localparam int FlagRi           = 4;
    localparam int FlagSyscall      = 5;
    localparam int FlagBreak        = 6;
    localparam int FlagEret         = 7;
    localparam int FlagTrap         = 8;
    localparam int FlagOverflow     = 9;
    localparam int FlagRdAddrErr    = 10;
    localparam int FlagWrAddrErr    = 11;
    localparam int ExcFlagW         = 12;

    localparam int ApbAddrW = 8;
    localparam logic [ApbAddrW-1:0] AddrStatus   = 8'h00;
    localparam logic [ApbAddrW-1:0] AddrCause    = 8'h04;
    localparam logic [ApbAddrW-1:0] AddrEpc      = 8'h08;
    localparam logic [ApbAddrW-1:0] AddrBadVAddr = 8'h0C;
    localparam logic [ApbAddrW-1:0] AddrEbase    = 8'h10;

    localparam logic [31:0] BootBase   = 32'hBFC00200; // used while Status.BEV is set
    localparam logic [31:0] GenOffset  = 32'h00000180;
    localparam logic [31:0] EbaseReset = 32'h80000000;

    // register field positions
    localparam int StatusBevBit = 22;
    localparam int StatusExlBit = 1;
    localparam int StatusIeBit  = 0;

endpackage
